//--- Makefile
VERILATOR ?= verilator
TOP       ?= trs_link_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard source/*.sv bench/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
	  echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/link_tests.txt
// test code, byte count, bytes, expected kind, expected value (all hex)
// kinds: 0 reply, 1 led, 2 color, 3 status, 4 audio, 5 addr, 6 error; ff ends the list
01 1 00 0 af
02 1 0f 0 03
03 2 1a 05 1 5
04 2 1a 07 1 7
05 4 11 12 34 56 2 123456
06 2 20 5a 3 5a
07 3 17 cd ab 5 abcd
08 2 22 00 4 0
09 1 99 6 1
0a 3 99 1a 06 1 6
ff

//--- bench/trs_link_sva.sv
`timescale 1ns/1ps
`default_nettype none

module trs_link_sva
  import trs_link_pkg::*;
(
  input wire         clk,
  input wire         cass_out_sel_n,
  input spi_byte_t   rx_byte,
  input cmd_strobe_t cmd
);

  // a command strobe lasts one cycle
  single_cycle_strobe: assert property (
    @(posedge clk) disable iff (!cass_out_sel_n) cmd.valid |=> !cmd.valid
  ) else $error("cmd.valid high for two cycles in a row");

  // framer answers a received byte one cycle later
  strobe_after_rx_byte: assert property (
    @(posedge clk) disable iff (!cass_out_sel_n) cmd.valid |-> $past(rx_byte.valid)
  ) else $error("cmd.valid without a rx_byte strobe in the cycle before");

  idle_in_reset: assert property (
    @(posedge clk) !cass_out_sel_n |-> (!cmd.valid && !cmd.unknown)
  ) else $error("cmd not at its reset value during reset");

endmodule

bind cmd_framer trs_link_sva sva_inst (
  .clk            (clk),
  .cass_out_sel_n (cass_out_sel_n),
  .rx_byte        (rx_byte),
  .cmd            (cmd)
);

`default_nettype wire

//--- bench/trs_link_tb.sv
`timescale 1ns/1ps
`default_nettype none

module trs_link_tb;

  localparam int sck_half        = 8;
  localparam int reset_cycles    = 4;
  localparam int cycles_per_test = 2000;

  // expected kinds as coded in the test file
  localparam logic [31:0] kind_reply  = 32'd0;
  localparam logic [31:0] kind_led    = 32'd1;
  localparam logic [31:0] kind_color  = 32'd2;
  localparam logic [31:0] kind_status = 32'd3;
  localparam logic [31:0] kind_audio  = 32'd4;
  localparam logic [31:0] kind_addr   = 32'd5;
  localparam logic [31:0] kind_error  = 32'd6;

  logic        clk;
  logic        cass_out_sel_n;
  logic        sck;
  logic        mosi;
  logic        cs_n;
  wire         miso;
  wire  [2:0]  led_rgb;
  wire  [23:0] screen_color;
  wire  [7:0]  esp_status;
  wire         audio_en;
  wire  [15:0] dsp_addr;
  wire         spi_error;

  logic [31:0] tests_mem [0:255];
  logic [7:0]  ptr;
  int          ntests;
  int          limit;
  int          cycles = 0;
  int          passed;
  int          failed;

  trs_link_top trs_link_top_inst (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .mosi           (mosi),
    .cs_n           (cs_n),
    .miso           (miso),
    .led_rgb        (led_rgb),
    .screen_color   (screen_color),
    .esp_status     (esp_status),
    .audio_en       (audio_en),
    .dsp_addr       (dsp_addr),
    .spi_error      (spi_error)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("timeout: tests still running after %0d clock cycles", cycles);
      $display("sim failed");
      $finish;
    end
  end

  // walk the records up to the ff marker
  function automatic int count_tests();
    logic [7:0] p;
    int         n;
    p = 8'd0;
    n = 0;
    while (n < 60 && tests_mem[p] !== 32'hff) begin
      p = p + tests_mem[p + 8'd1][7:0] + 8'd4;
      n++;
    end
    count_tests = n;
  endfunction

  function automatic logic [31:0] observed(input logic [31:0] kind, input logic [7:0] reply);
    case (kind)
      kind_reply:  observed = {24'd0, reply};
      kind_led:    observed = {29'd0, led_rgb};
      kind_color:  observed = {8'd0, screen_color};
      kind_status: observed = {24'd0, esp_status};
      kind_audio:  observed = {31'd0, audio_en};
      kind_addr:   observed = {16'd0, dsp_addr};
      kind_error:  observed = {31'd0, spi_error};
      default:     observed = 32'hdeadbeef;
    endcase
  endfunction

  // mode 0 with msb first and miso taken just before sck rises
  task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
    logic [7:0] sr;
    sr = tx;
    rx = 8'h00;
    repeat (8) begin
      mosi = sr[7];
      sr   = {sr[6:0], 1'b0};
      repeat (sck_half) @(negedge clk);
      rx  = {rx[6:0], miso};
      sck = 1'b1;
      repeat (sck_half) @(negedge clk);
      sck = 1'b0;
    end
  endtask

  task automatic check_reset_values();
    if (led_rgb !== 3'd0 || screen_color !== 24'hFFFFFF || esp_status !== 8'h00 ||
        audio_en !== 1'b1 || dsp_addr !== 16'h0000 || spi_error !== 1'b0 || miso !== 1'b0) begin
      $display("ERR t=%0t reset: expected led 0 color ffffff status 0 audio 1 addr 0 error 0",
               $time);
      $display("ERR t=%0t reset: got led %0h color %0h status %0h audio %0b addr %0h error %0b",
               $time, led_rgb, screen_color, esp_status, audio_en, dsp_addr, spi_error);
      $display("test reset: fail");
      failed++;
    end else begin
      $display("test reset: ok");
      passed++;
    end
  endtask

  task automatic run_test();
    logic [31:0] code;
    logic [7:0]  nbytes;
    logic [31:0] kind;
    logic [31:0] expected;
    logic [31:0] actual;
    logic [7:0]  reply_byte;
    code       = tests_mem[ptr];
    nbytes     = tests_mem[ptr + 8'd1][7:0];
    kind       = tests_mem[ptr + 8'd2 + nbytes];
    ptr        = ptr + 8'd2;
    reply_byte = 8'h00;
    @(negedge clk);
    cs_n = 1'b0;
    repeat (nbytes) begin
      shift_byte(tests_mem[ptr][7:0], reply_byte);
      ptr = ptr + 8'd1;
    end
    // reply comes out during one more get_cookie byte
    if (kind == kind_reply) begin
      shift_byte(8'h00, reply_byte);
    end
    // registers settle within 6 clk of the last sck rise
    repeat (sck_half) @(negedge clk);
    cs_n = 1'b1;
    repeat (sck_half) @(negedge clk);
    expected = tests_mem[ptr + 8'd1];
    ptr      = ptr + 8'd2;
    actual   = observed(kind, reply_byte);
    if (actual !== expected) begin
      $display("ERR t=%0t test %0h: expected %0h, got %0h", $time, code, expected, actual);
      $display("test %0h: fail", code);
      failed++;
    end else begin
      $display("test %0h: ok", code);
      passed++;
    end
  endtask

  initial begin
    clk            = 1'b0;
    cass_out_sel_n = 1'b0;
    sck            = 1'b0;
    mosi           = 1'b0;
    cs_n           = 1'b1;
    passed         = 0;
    failed         = 0;
    ptr            = 8'd0;
    $readmemh("bench/link_tests.txt", tests_mem);
    ntests = count_tests();
    limit  = ntests * cycles_per_test + 1000;
    repeat (reset_cycles) @(negedge clk);
    cass_out_sel_n = 1'b1;
    @(negedge clk);
    check_reset_values();
    if (ntests == 0) begin
      $display("no tests found in bench/link_tests.txt");
      failed++;
    end
    for (int t = 0; t < ntests; t++) begin
      run_test();
    end
    $display("tests passed %0d, failed %0d", passed, failed);
    if (failed == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/cmd_framer.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_framer
  import trs_link_pkg::*;
(
  input  wire          clk,
  input  wire          cass_out_sel_n,
  input  spi_byte_t    rx_byte,
  output cmd_strobe_t  cmd
);

  typedef enum logic {
    st_idle,
    st_params
  } state_e;

  state_e       state;
  logic [1:0]   remain;
  logic [1:0]   idx;
  logic [1:0]   op_count;
  logic         op_known;
  logic         cmd_valid;
  cmd_op_e      op_q;
  logic         unknown_q;
  cmd_payload_u payload_q;

  always_comb begin
    op_count = param_count(rx_byte.data, op_known);
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state     <= st_idle;
      remain    <= 2'd0;
      idx       <= 2'd0;
      cmd_valid <= 1'b0;
      op_q      <= get_cookie;
      unknown_q <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      if (rx_byte.valid) begin
        case (state)
          st_idle: begin
            op_q      <= cmd_op_e'(rx_byte.data);
            unknown_q <= ~op_known;
            idx       <= 2'd0;
            remain    <= op_count;
            // unknown opcodes complete at once so the next byte is an opcode again
            if (!op_known || op_count == 2'd0) begin
              cmd_valid <= 1'b1;
            end else begin
              state <= st_params;
            end
          end
          st_params: begin
            idx <= idx + 2'd1;
            if (remain == 2'd1) begin
              cmd_valid <= 1'b1;
              state     <= st_idle;
            end else begin
              remain <= remain - 2'd1;
            end
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

  // parameter bytes land in receive order
  always_ff @(posedge clk) begin
    if (rx_byte.valid && state == st_params) begin
      case (idx)
        2'd0:    payload_q.bytes.p0 <= rx_byte.data;
        2'd1:    payload_q.bytes.p1 <= rx_byte.data;
        default: payload_q.bytes.p2 <= rx_byte.data;
      endcase
    end else if (rx_byte.valid) begin
      payload_q <= '0;
    end
  end

  assign cmd = '{valid: cmd_valid, op: op_q, unknown: unknown_q, payload: payload_q};

endmodule

`default_nettype wire

//--- source/cmd_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_regs
  import trs_link_pkg::*;
#(
  parameter logic [7:0] COOKIE        = 8'hAF,
  parameter logic [2:0] VERSION_MAJOR = 3'd0,
  parameter logic [4:0] VERSION_MINOR = 5'd3
) (
  input  wire          clk,
  input  wire          cass_out_sel_n,
  input  cmd_strobe_t  cmd,
  output spi_byte_t    tx_byte,
  output logic [2:0]   led_rgb,
  output logic [23:0]  screen_color,
  output logic [7:0]   esp_status,
  output logic         audio_en,
  output logic [15:0]  dsp_addr,
  output logic         spi_error
);

  localparam version_t version = '{major: VERSION_MAJOR, minor: VERSION_MINOR};

  logic       tx_valid;
  logic [7:0] tx_data;
  logic       do_cmd;

  assign do_cmd = cmd.valid & ~cmd.unknown;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led_rgb      <= 3'b000;
      screen_color <= screen_color_reset;
      esp_status   <= 8'h00;
      audio_en     <= 1'b1;
      dsp_addr     <= 16'h0000;
      spi_error    <= 1'b0;
      tx_valid     <= 1'b0;
    end else begin
      tx_valid <= 1'b0;
      // sticky until reset
      if (cmd.valid && cmd.unknown) begin
        spi_error <= 1'b1;
      end
      if (do_cmd) begin
        case (cmd.op)
          get_cookie,
          get_version:      tx_valid     <= 1'b1;
          set_led:          led_rgb      <= cmd.payload.bytes.p0[2:0];
          set_screen_color: screen_color <= {cmd.payload.bytes.p0,
                                             cmd.payload.bytes.p1,
                                             cmd.payload.bytes.p2};
          set_esp_status:   esp_status   <= cmd.payload.bytes.p0;
          set_audio_output: audio_en     <= cmd.payload.bytes.p0[0];
          z80_dsp_set_addr: dsp_addr     <= cmd.payload.addr.addr;
          default:          tx_valid     <= 1'b0;
        endcase
      end
    end
  end

  // reply data qualified by tx_valid
  always_ff @(posedge clk) begin
    if (do_cmd && cmd.op == get_cookie) begin
      tx_data <= COOKIE;
    end else if (do_cmd && cmd.op == get_version) begin
      tx_data <= version;
    end
  end

  assign tx_byte = '{valid: tx_valid, data: tx_data};

endmodule

`default_nettype wire

//--- source/spi_byte_link.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte_link
  import trs_link_pkg::*;
(
  input  wire        clk,
  input  wire        cass_out_sel_n,
  input  wire        sck,
  input  wire        mosi,
  input  wire        cs_n,
  output logic       miso,
  input  spi_byte_t  tx_byte,
  output spi_byte_t  rx_byte
);

  logic [2:0] sck_s;
  logic [2:0] cs_s;
  logic [2:0] mosi_s;
  logic       sck_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic [2:0] bitcnt;
  logic       rx_valid;
  logic [7:0] rx_shift;
  logic [7:0] reply;
  logic [7:0] tx_shift;

  // three flops on every pin and one more on sck for edge detect
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_s  <= 3'b000;
      cs_s   <= 3'b111;
      mosi_s <= 3'b000;
      sck_q  <= 1'b0;
    end else begin
      sck_s  <= {sck_s[1:0], sck};
      cs_s   <= {cs_s[1:0], cs_n};
      mosi_s <= {mosi_s[1:0], mosi};
      sck_q  <= sck_s[2];
    end
  end

  assign sck_rise  = sck_s[2] & ~sck_q;
  assign sck_fall  = ~sck_s[2] & sck_q;
  assign cs_active = ~cs_s[2];

  // bit count clears whenever the frame is closed
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bitcnt   <= 3'd0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        bitcnt <= 3'd0;
      end else if (sck_rise) begin
        bitcnt <= bitcnt + 3'd1;
        if (bitcnt == 3'd7) begin
          rx_valid <= 1'b1;
        end
      end
    end
  end

  // msb first
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[6:0], mosi_s[2]};
    end
  end

  assign rx_byte = '{valid: rx_valid, data: rx_shift};

  // held until the next get command replaces it
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      reply <= reply_idle;
    end else if (tx_byte.valid) begin
      reply <= tx_byte.data;
    end
  end

  // between bytes keep bit 7 of the reply ready on miso
  always_ff @(posedge clk) begin
    if (bitcnt == 3'd0 && !(cs_active && sck_rise)) begin
      tx_shift <= reply;
    end else if (cs_active && sck_fall) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  assign miso = cs_active ? tx_shift[7] : 1'b0;

endmodule

`default_nettype wire

//--- source/trs_link_pkg.sv
`default_nettype none

package trs_link_pkg;

  // opcodes on the ESP command link
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    get_version      = 8'd15,
    set_screen_color = 8'd17,
    z80_dsp_set_addr = 8'd23,
    set_led          = 8'd26,
    set_esp_status   = 8'd32,
    set_audio_output = 8'd34
  } cmd_op_e;

  // one byte to or from the serial port
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } spi_byte_t;

  // p0 arrives first and sits in the low byte
  typedef struct packed {
    logic [7:0] p2;
    logic [7:0] p1;
    logic [7:0] p0;
  } cmd_bytes_t;

  // display address view where addr equals {p1,p0}
  typedef struct packed {
    logic [7:0]  data;
    logic [15:0] addr;
  } cmd_addr_t;

  typedef union packed {
    cmd_bytes_t bytes;
    cmd_addr_t  addr;
  } cmd_payload_u;

  typedef struct packed {
    logic         valid;
    cmd_op_e      op;
    logic         unknown;
    cmd_payload_u payload;
  } cmd_strobe_t;

  typedef struct packed {
    logic [2:0] major;
    logic [4:0] minor;
  } version_t;

  // reply shifted out before any get command has run
  localparam logic [7:0]  reply_idle         = 8'h00;
  localparam logic [23:0] screen_color_reset = 24'hFFFFFF;

  // number of parameter bytes for an opcode
  // known goes low for any opcode not listed
  function automatic logic [1:0] param_count(input logic [7:0] op, output logic known);
    known = 1'b1;
    case (op)
      get_cookie,
      get_version:      param_count = 2'd0;
      set_led,
      set_esp_status,
      set_audio_output: param_count = 2'd1;
      z80_dsp_set_addr: param_count = 2'd2;
      set_screen_color: param_count = 2'd3;
      default: begin
        param_count = 2'd0;
        known       = 1'b0;
      end
    endcase
  endfunction

endpackage

`default_nettype wire

//--- source/trs_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module trs_link_top
  import trs_link_pkg::*;
#(
  parameter logic [7:0] COOKIE        = 8'hAF,
  parameter logic [2:0] VERSION_MAJOR = 3'd0,
  parameter logic [4:0] VERSION_MINOR = 5'd3
) (
  input  wire         clk,
  input  wire         cass_out_sel_n,
  input  wire         sck,
  input  wire         mosi,
  input  wire         cs_n,
  output logic        miso,
  output logic [2:0]  led_rgb,
  output logic [23:0] screen_color,
  output logic [7:0]  esp_status,
  output logic        audio_en,
  output logic [15:0] dsp_addr,
  output logic        spi_error
);

  spi_byte_t   rx_byte;
  spi_byte_t   tx_byte;
  cmd_strobe_t cmd;

  spi_byte_link u_link (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .mosi           (mosi),
    .cs_n           (cs_n),
    .miso           (miso),
    .tx_byte        (tx_byte),
    .rx_byte        (rx_byte)
  );

  cmd_framer u_framer (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .rx_byte        (rx_byte),
    .cmd            (cmd)
  );

  cmd_regs #(
    .COOKIE        (COOKIE),
    .VERSION_MAJOR (VERSION_MAJOR),
    .VERSION_MINOR (VERSION_MINOR)
  ) u_regs (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cmd            (cmd),
    .tx_byte        (tx_byte),
    .led_rgb        (led_rgb),
    .screen_color   (screen_color),
    .esp_status     (esp_status),
    .audio_en       (audio_en),
    .dsp_addr       (dsp_addr),
    .spi_error      (spi_error)
  );

endmodule

`default_nettype wire

//--- sources.f
source/trs_link_pkg.sv
source/spi_byte_link.sv
source/cmd_framer.sv
source/cmd_regs.sv
source/trs_link_top.sv
bench/trs_link_tb.sv
bench/trs_link_sva.sv
